/* src/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

        // Instructions and data words share the same 32-bit width
        typedef logic [31:0] word_t;

        // Primary opcode, bits 31 to 26 of every instruction
        typedef logic [5:0] opcode_t;

        // Function field, bits 5 to 0, meaningful only for R-type
        typedef logic [5:0] funct_t;

        // Primary opcodes of the supported subset
        localparam opcode_t opcode_rtype = 6'h00;
        localparam opcode_t opcode_jal   = 6'h03;
        localparam opcode_t opcode_bne   = 6'h05;
        // jr lives in the primary opcode space, not under R-type
        localparam opcode_t opcode_jr    = 6'h08;
        localparam opcode_t opcode_xori  = 6'h0e;
        localparam opcode_t opcode_lw    = 6'h23;
        localparam opcode_t opcode_sw    = 6'h2b;

        // R-type function codes
        localparam funct_t funct_add = 6'h20;
        localparam funct_t funct_sub = 6'h22;
        localparam funct_t funct_slt = 6'h2a;

        // Operations the execute stage can perform
        typedef enum logic [2:0] {
                alu_add = 3'b000,
                alu_sub = 3'b001,
                alu_xor = 3'b010,
                alu_slt = 3'b011
        } alu_cmd_t;

endpackage

`default_nettype wire

/* src/cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

        // Register number, as found in the rs, rt and rd fields
        typedef logic [4:0] reg_index_t;

        // Byte address used for fetch and for data accesses
        typedef logic [31:0] pc_t;

        // jal saves its return address here
        localparam reg_index_t link_register = 5'd31;

        // First fetch address once reset is released
        localparam pc_t reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

/* src/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
        input  wire cpu_isa_pkg::opcode_t op,
        input  wire cpu_isa_pkg::funct_t  funct,
        output logic                      reg_write_id,
        output logic                      mem_to_reg_id,
        output logic                      mem_write_id,
        output logic                      branch_id,
        output logic                      jump_id,
        output logic                      link_id,
        output cpu_isa_pkg::alu_cmd_t     alu_control_id,
        output logic                      alu_src_id,
        output logic                      reg_dst_id
);
        import cpu_isa_pkg::*;

        always_comb begin
                // Start from a bubble so that anything unrecognised writes nothing
                reg_write_id   = 1'b0;
                mem_to_reg_id  = 1'b0;
                mem_write_id   = 1'b0;
                branch_id      = 1'b0;
                jump_id        = 1'b0;
                link_id        = 1'b0;
                alu_control_id = alu_add;
                alu_src_id     = 1'b0;
                reg_dst_id     = 1'b0;
                case (op)
                        opcode_lw: begin
                                // Address is rs plus the signed offset, data goes to rt
                                reg_write_id  = 1'b1;
                                mem_to_reg_id = 1'b1;
                                alu_src_id    = 1'b1;
                        end
                        opcode_sw: begin
                                // Same address math as lw, rt supplies the store data
                                mem_write_id = 1'b1;
                                alu_src_id   = 1'b1;
                        end
                        opcode_xori: begin
                                reg_write_id   = 1'b1;
                                alu_control_id = alu_xor;
                                alu_src_id     = 1'b1;
                        end
                        opcode_bne: begin
                                // Execute subtracts rs and rt and branches on a nonzero result
                                branch_id      = 1'b1;
                                alu_control_id = alu_sub;
                        end
                        opcode_jal: begin
                                // Redirects from decode and writes PC+4 to the link register
                                reg_write_id = 1'b1;
                                jump_id      = 1'b1;
                                link_id      = 1'b1;
                        end
                        opcode_jr: begin
                                // Target comes from rs, nothing is written back
                                jump_id = 1'b1;
                        end
                        opcode_rtype: begin
                                // Only the three supported function codes leave the bubble
                                case (funct)
                                        funct_add: begin
                                                reg_write_id   = 1'b1;
                                                alu_control_id = alu_add;
                                                reg_dst_id     = 1'b1;
                                        end
                                        funct_sub: begin
                                                reg_write_id   = 1'b1;
                                                alu_control_id = alu_sub;
                                                reg_dst_id     = 1'b1;
                                        end
                                        funct_slt: begin
                                                reg_write_id   = 1'b1;
                                                alu_control_id = alu_slt;
                                                reg_dst_id     = 1'b1;
                                        end
                                        default: begin
                                                reg_write_id = 1'b0;
                                        end
                                endcase
                        end
                        default: begin
                                reg_write_id = 1'b0;
                        end
                endcase
        end

        // A known opcode must always give a fully known control set
        always_comb begin
                if (!$isunknown(op)) begin
                        assert (!$isunknown({reg_write_id, mem_to_reg_id, mem_write_id,
                                             branch_id, jump_id, link_id, alu_control_id,
                                             alu_src_id, reg_dst_id}))
                        else $error("control_unit: unknown control output for op %h", op);
                end
        end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
        input  wire cpu_isa_pkg::word_t    a,
        input  wire cpu_isa_pkg::word_t    b,
        input  wire cpu_isa_pkg::alu_cmd_t cmd,
        output cpu_isa_pkg::word_t         result,
        output logic                       zero
);
        import cpu_isa_pkg::*;

        always_comb begin
                case (cmd)
                        alu_add: result = a + b;
                        alu_sub: result = a - b;
                        alu_xor: result = a ^ b;
                        // Two's complement compare, so -1 is less than 1
                        alu_slt: result = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
                        default: result = a + b;
                endcase
        end

        // bne uses this with the sub command, so zero means the operands match
        assign zero = (result == '0);

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
        input  wire                          clk,
        input  wire                          reset,
        input  wire cpu_pipe_pkg::reg_index_t read_addr_a,
        input  wire cpu_pipe_pkg::reg_index_t read_addr_b,
        input  wire cpu_pipe_pkg::reg_index_t write_addr,
        input  wire                          write_enable,
        input  wire cpu_isa_pkg::word_t      write_data,
        output cpu_isa_pkg::word_t           read_data_a,
        output cpu_isa_pkg::word_t           read_data_b
);
        import cpu_isa_pkg::*;

        word_t regs [32];
        logic  write_live;

        // Register 0 is never written, so it keeps the zero from reset
        assign write_live = write_enable && (write_addr != '0);

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (write_live) begin
                        regs[write_addr] <= write_data;
                end
        end

        // Write-through lets decode see a result in the same cycle it is written back
        assign read_data_a = (write_live && write_addr == read_addr_a) ? write_data
                                                                      : regs[read_addr_a];
        assign read_data_b = (write_live && write_addr == read_addr_b) ? write_data
                                                                      : regs[read_addr_b];

        // Register 0 reads zero on both ports, also while it is being targeted
        assert property (@(posedge clk) disable iff (reset)
                (read_addr_a != '0 || read_data_a == '0) &&
                (read_addr_b != '0 || read_data_b == '0))
        else $error("register_file: register 0 read back nonzero");

endmodule

`default_nettype wire

/* src/word_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module word_memory #(
        parameter int depth = 64
) (
        input  wire                     clk,
        input  wire                     write,
        input  wire cpu_pipe_pkg::pc_t  addr,
        input  wire cpu_isa_pkg::word_t wdata,
        output cpu_isa_pkg::word_t      rdata
);
        import cpu_isa_pkg::*;

        localparam int index_width = (depth > 1) ? $clog2(depth) : 1;

        word_t                  mem [depth];
        logic [index_width-1:0] index;

        // Word addressing, the two byte-offset bits are dropped
        assign index = addr[index_width+1:2];

        always_ff @(posedge clk) begin
                if (write) begin
                        mem[index] <= wdata;
                end
        end

        assign rdata = mem[index];

        // Upper address bits would otherwise alias a write onto a lower word
        assert property (@(posedge clk) write |-> (addr[31:2] < depth))
        else $error("word_memory: write to %h is beyond %0d words", addr, depth);

endmodule

`default_nettype wire

/* src/cpu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
        input  wire                     clk,
        input  wire                     reset,
        output cpu_pipe_pkg::pc_t       instr_addr,
        input  wire cpu_isa_pkg::word_t instr,
        output cpu_pipe_pkg::pc_t       data_addr,
        output cpu_isa_pkg::word_t      data_wdata,
        output logic                    data_write,
        input  wire cpu_isa_pkg::word_t data_rdata
);
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        // Fetch
        pc_t pc;
        pc_t pc_plus4;
        pc_t pc_next;

        // IF/ID register
        logic  if_id_valid;
        word_t if_id_instr;
        pc_t   if_id_pc_plus4;

        // Decode
        logic [15:0] id_imm16;
        word_t       id_imm;
        word_t       id_rs_data;
        word_t       id_rt_data;
        reg_index_t  id_dest;
        logic        id_reg_write;
        logic        id_mem_to_reg;
        logic        id_mem_write;
        logic        id_branch;
        logic        id_jump;
        logic        id_link;
        alu_cmd_t    id_alu_cmd;
        logic        id_alu_src;
        logic        id_reg_dst;
        logic        id_jump_taken;
        pc_t         id_jump_target;

        // ID/EX register
        logic       id_ex_valid;
        logic       id_ex_reg_write;
        logic       id_ex_mem_to_reg;
        logic       id_ex_mem_write;
        logic       id_ex_branch;
        logic       id_ex_link;
        alu_cmd_t   id_ex_alu_cmd;
        logic       id_ex_alu_src;
        reg_index_t id_ex_dest;
        word_t      id_ex_rs_data;
        word_t      id_ex_rt_data;
        word_t      id_ex_imm;
        pc_t        id_ex_pc_plus4;

        // Execute
        word_t ex_alu_b;
        word_t ex_alu_result;
        word_t ex_result;
        logic  ex_zero;
        logic  ex_branch_taken;
        pc_t   ex_branch_target;

        // EX/MEM register
        logic       ex_mem_valid;
        logic       ex_mem_reg_write;
        logic       ex_mem_mem_to_reg;
        logic       ex_mem_mem_write;
        reg_index_t ex_mem_dest;
        word_t      ex_mem_result;
        word_t      ex_mem_store_data;

        // MEM/WB register
        logic       mem_wb_valid;
        logic       mem_wb_reg_write;
        reg_index_t mem_wb_dest;
        word_t      mem_wb_result;

        assign instr_addr = pc;
        assign pc_plus4   = pc + 32'd4;

        // The older bne in execute wins over a jump in decode, which it squashes anyway
        assign pc_next = ex_branch_taken ? ex_branch_target :
                         id_jump_taken   ? id_jump_target   : pc_plus4;

        control_unit u_control (
                .op             (if_id_instr[31:26]),
                .funct          (if_id_instr[5:0]),
                .reg_write_id   (id_reg_write),
                .mem_to_reg_id  (id_mem_to_reg),
                .mem_write_id   (id_mem_write),
                .branch_id      (id_branch),
                .jump_id        (id_jump),
                .link_id        (id_link),
                .alu_control_id (id_alu_cmd),
                .alu_src_id     (id_alu_src),
                .reg_dst_id     (id_reg_dst)
        );

        register_file u_regs (
                .clk          (clk),
                .reset        (reset),
                .read_addr_a  (if_id_instr[25:21]),
                .read_addr_b  (if_id_instr[20:16]),
                .write_addr   (mem_wb_dest),
                .write_enable (mem_wb_valid && mem_wb_reg_write),
                .write_data   (mem_wb_result),
                .read_data_a  (id_rs_data),
                .read_data_b  (id_rt_data)
        );

        // xori takes a zero-extended immediate, lw, sw and bne a signed one
        assign id_imm16 = if_id_instr[15:0];
        assign id_imm   = (if_id_instr[31:26] == opcode_xori) ? {16'b0, id_imm16}
                                                             : {{16{id_imm16[15]}}, id_imm16};

        assign id_dest = id_link    ? link_register      :
                         id_reg_dst ? if_id_instr[15:11] : if_id_instr[20:16];

        // jal jumps within the current 256 MB region, jr jumps through rs
        assign id_jump_taken  = if_id_valid && id_jump;
        assign id_jump_target = id_link ? {if_id_pc_plus4[31:28], if_id_instr[25:0], 2'b00}
                                        : id_rs_data;

        assign ex_alu_b = id_ex_alu_src ? id_ex_imm : id_ex_rt_data;

        alu u_alu (
                .a      (id_ex_rs_data),
                .b      (ex_alu_b),
                .cmd    (id_ex_alu_cmd),
                .result (ex_alu_result),
                .zero   (ex_zero)
        );

        // jal carries its return address down the pipe in place of an ALU result
        assign ex_result        = id_ex_link ? id_ex_pc_plus4 : ex_alu_result;
        assign ex_branch_taken  = id_ex_valid && id_ex_branch && !ex_zero;
        assign ex_branch_target = id_ex_pc_plus4 + {id_ex_imm[29:0], 2'b00};

        // Memory stage drives the data port directly
        assign data_addr  = ex_mem_result;
        assign data_wdata = ex_mem_store_data;
        assign data_write = ex_mem_valid && ex_mem_mem_write;

        // PC and valid bits, a cleared valid bit marks a bubble
        always_ff @(posedge clk) begin
                if (reset) begin
                        pc           <= reset_pc;
                        if_id_valid  <= 1'b0;
                        id_ex_valid  <= 1'b0;
                        ex_mem_valid <= 1'b0;
                        mem_wb_valid <= 1'b0;
                end else begin
                        pc           <= pc_next;
                        if_id_valid  <= !(ex_branch_taken || id_jump_taken);
                        id_ex_valid  <= if_id_valid && !ex_branch_taken;
                        ex_mem_valid <= id_ex_valid;
                        mem_wb_valid <= ex_mem_valid;
                end
        end

        // Stage payloads, qualified downstream by the valid bits
        always_ff @(posedge clk) begin
                if_id_instr       <= instr;
                if_id_pc_plus4    <= pc_plus4;
                id_ex_reg_write   <= id_reg_write;
                id_ex_mem_to_reg  <= id_mem_to_reg;
                id_ex_mem_write   <= id_mem_write;
                id_ex_branch      <= id_branch;
                id_ex_link        <= id_link;
                id_ex_alu_cmd     <= id_alu_cmd;
                id_ex_alu_src     <= id_alu_src;
                id_ex_dest        <= id_dest;
                id_ex_rs_data     <= id_rs_data;
                id_ex_rt_data     <= id_rt_data;
                id_ex_imm         <= id_imm;
                id_ex_pc_plus4    <= if_id_pc_plus4;
                ex_mem_reg_write  <= id_ex_reg_write;
                ex_mem_mem_to_reg <= id_ex_mem_to_reg;
                ex_mem_mem_write  <= id_ex_mem_write;
                ex_mem_dest       <= id_ex_dest;
                ex_mem_result     <= ex_result;
                ex_mem_store_data <= id_ex_rt_data;
                mem_wb_reg_write  <= ex_mem_reg_write;
                mem_wb_dest       <= ex_mem_dest;
                mem_wb_result     <= ex_mem_mem_to_reg ? data_rdata : ex_mem_result;
        end

        // Software keeps jumps out of the bne shadow, so both redirects never meet
        assert property (@(posedge clk) disable iff (reset) ex_branch_taken |-> !id_jump_taken)
        else $error("cpu_core: bne redirect coincides with a decode-stage jump");

endmodule

`default_nettype wire

/* src/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
        parameter int imem_depth = 64,
        parameter int dmem_depth = 64
) (
        input  wire                     clk,
        input  wire                     reset,
        input  wire                     imem_write,
        input  wire cpu_pipe_pkg::pc_t  imem_addr,
        input  wire cpu_isa_pkg::word_t imem_data,
        output logic                    store_valid,
        output cpu_pipe_pkg::pc_t       store_addr,
        output cpu_isa_pkg::word_t      store_data
);
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        pc_t   instr_addr;
        pc_t   imem_port_addr;
        word_t instr;
        pc_t   data_addr;
        word_t data_wdata;
        logic  data_write;
        word_t data_rdata;

        // Program load borrows the instruction port while the core sits in reset
        assign imem_port_addr = imem_write ? imem_addr : instr_addr;

        cpu_core u_core (
                .clk        (clk),
                .reset      (reset),
                .instr_addr (instr_addr),
                .instr      (instr),
                .data_addr  (data_addr),
                .data_wdata (data_wdata),
                .data_write (data_write),
                .data_rdata (data_rdata)
        );

        word_memory #(.depth(imem_depth)) u_imem (
                .clk   (clk),
                .write (imem_write),
                .addr  (imem_port_addr),
                .wdata (imem_data),
                .rdata (instr)
        );

        word_memory #(.depth(dmem_depth)) u_dmem (
                .clk   (clk),
                .write (data_write),
                .addr  (data_addr),
                .wdata (data_wdata),
                .rdata (data_rdata)
        );

        // Every store is visible outside in the same cycle it strobes the memory
        assign store_valid = data_write;
        assign store_addr  = data_addr;
        assign store_data  = data_wdata;

endmodule

`default_nettype wire

/* testbench/cpu_tb_program.svh */
`ifndef cpu_tb_program_svh
`define cpu_tb_program_svh

// Hand-assembled test program with one word per instruction starting at address 0
// Each producer is followed by at least two independent instructions before its consumer
localparam int program_length = 32;

localparam word_t program_words [program_length] = '{
        32'h3801_0005,  // 00 xori r1, r0, 5
        32'h3802_0003,  // 04 xori r2, r0, 3
        32'h3803_0001,  // 08 xori r3, r0, 1
        32'hAC01_0000,  // 0C sw   r1, 0x00(r0)
        32'h0022_2020,  // 10 add  r4, r1, r2
        32'h0041_2822,  // 14 sub  r5, r2, r1
        32'h0003_3022,  // 18 sub  r6, r0, r3
        32'hAC04_0004,  // 1C sw   r4, 0x04(r0)
        32'hAC05_0008,  // 20 sw   r5, 0x08(r0)
        32'h00C3_382A,  // 24 slt  r7, r6, r3
        32'h0066_402A,  // 28 slt  r8, r3, r6
        32'hAC06_000C,  // 2C sw   r6, 0x0C(r0)
        32'hAC07_0010,  // 30 sw   r7, 0x10(r0)
        32'hAC08_0014,  // 34 sw   r8, 0x14(r0)
        32'h8C09_000C,  // 38 lw   r9, 0x0C(r0)
        32'h380A_8007,  // 3C xori r10, r0, 0x8007   bit 15 set, so zero extension shows
        32'h1421_0002,  // 40 bne  r1, r1, +2   never taken
        32'hAC09_0018,  // 44 sw   r9, 0x18(r0)
        32'h1422_0003,  // 48 bne  r1, r2, +3   taken to 58
        32'hAC01_001C,  // 4C sw   r1, 0x1C(r0)   squashed
        32'hAC02_001C,  // 50 sw   r2, 0x1C(r0)   squashed
        32'hAC03_001C,  // 54 sw   r3, 0x1C(r0)   jumped over
        32'hAC0A_001C,  // 58 sw   r10, 0x1C(r0)
        32'h0C00_001C,  // 5C jal  70
        32'hAC04_0024,  // 60 sw   r4, 0x24(r0)   runs after the return
        32'h0C00_0019,  // 64 jal  64   parks the core
        32'h0000_0000,  // 68 nop
        32'h0000_0000,  // 6C nop
        32'h380B_00AA,  // 70 xori r11, r0, 0xAA
        32'hAC1F_0020,  // 74 sw   r31, 0x20(r0)
        32'h23E0_0000,  // 78 jr   r31
        32'hAC0B_0028   // 7C sw   r11, 0x28(r0)   squashed by jr
};

// Stores in the order they must leave the memory stage
localparam int store_count = 10;

localparam pc_t expected_addr [store_count] = '{
        32'h00, 32'h04, 32'h08, 32'h0C, 32'h10,
        32'h14, 32'h18, 32'h1C, 32'h20, 32'h24
};

// 5, 5+3, 3-5, 0-1, slt(-1,1), slt(1,-1), the lw copy, r10, the jal link, r4 again
localparam word_t expected_data [store_count] = '{
        32'h0000_0005, 32'h0000_0008, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 32'h0000_0001,
        32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_8007, 32'h0000_0060, 32'h0000_0008
};

`endif

/* testbench/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        localparam int imem_depth = 64;
        localparam int dmem_depth = 64;
        localparam int max_cycles = 2000;

        `include "cpu_tb_program.svh"

        logic  clk;
        logic  reset;
        logic  imem_write;
        pc_t   imem_addr;
        word_t imem_data;
        logic  store_valid;
        pc_t   store_addr;
        word_t store_data;

        // Index of the next expected store, moved on at the rising edge
        int store_index;
        int value_errors;
        int other_errors;

        cpu_top #(
                .imem_depth (imem_depth),
                .dmem_depth (dmem_depth)
        ) UUT (
                .clk         (clk),
                .reset       (reset),
                .imem_write  (imem_write),
                .imem_addr   (imem_addr),
                .imem_data   (imem_data),
                .store_valid (store_valid),
                .store_addr  (store_addr),
                .store_data  (store_data)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #50 clk = ~clk;
                end
        end

        always @(posedge clk) begin
                if (reset) begin
                        store_index <= 0;
                end else if (store_valid) begin
                        store_index <= store_index + 1;
                end
        end

        // The pipeline holds only bubbles while reset is high, the load included
        quiet_during_reset: assert property (@(negedge clk) reset |-> !store_valid)
        else begin
                value_errors++;
                $display("FAILED at %0t: store_valid expected 0, got %b", $time, store_valid);
        end

        // Outputs change at the rising edge, so the falling edge sees them settled
        store_addr_check: assert property (@(negedge clk) disable iff (reset)
                (store_valid && store_index < store_count) |->
                store_addr == expected_addr[store_index])
        else begin
                value_errors++;
                $display("FAILED at %0t: store_addr expected %h, got %h",
                         $time, expected_addr[store_index], store_addr);
        end

        store_data_check: assert property (@(negedge clk) disable iff (reset)
                (store_valid && store_index < store_count) |->
                store_data == expected_data[store_index])
        else begin
                value_errors++;
                $display("FAILED at %0t: store_data expected %h, got %h",
                         $time, expected_data[store_index], store_data);
        end

        // Squashed or jumped-over stores would show up as extras here
        extra_store_check: assert property (@(negedge clk) disable iff (reset)
                store_valid |-> store_index < store_count)
        else begin
                other_errors++;
                $display("Unexpected store of %h to %h at %0t, all %0d stores were already seen",
                         store_data, store_addr, $time, store_count);
        end

        initial begin
                int cycles;

                reset      = 1'b1;
                imem_write = 1'b0;
                imem_addr  = '0;
                imem_data  = '0;
                cycles     = 0;

                // One word per cycle through the load port while the core is held
                @(negedge clk);
                for (int i = 0; i < program_length; i++) begin
                        imem_write = 1'b1;
                        imem_addr  = pc_t'(i * 4);
                        imem_data  = program_words[i];
                        @(negedge clk);
                end
                imem_write = 1'b0;
                imem_addr  = '0;
                imem_data  = '0;

                // Reset then stays high for ten clean cycles before the first fetch
                repeat (10) @(negedge clk);
                reset = 1'b0;

                while (store_index < store_count && cycles < max_cycles) begin
                        @(negedge clk);
                        cycles++;
                end

                if (store_index < store_count) begin
                        other_errors++;
                        $display("Timed out after %0d cycles with %0d of %0d stores seen",
                                 cycles, store_index, store_count);
                end else begin
                        // The core should now sit in its final loop without storing
                        repeat (10) @(negedge clk);
                end

                $display("Errors: %0d value mismatches, %0d other failures",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/control_unit.sv
src/alu.sv
src/register_file.sv
src/word_memory.sv
src/cpu_core.sv
src/cpu_top.sv
testbench/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the pipelined core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

./obj_dir/cpu_tb_sim > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
        echo "Simulation ended with status $status"
        exit 1
fi

if grep -q "Test failed" "$log_file"; then
        echo "Simulation reported a failure"
        exit 1
fi

if ! grep -q "Test completed successfully" "$log_file"; then
        echo "Simulation finished without a verdict"
        exit 1
fi

exit 0
